/* filelist.f */
+incdir+verification
rtl/bpu_pkg.sv
rtl/dual_port_ram.sv
rtl/btb.sv
rtl/bpu.sv
rtl/branch_predictor_top.sv
verification/bpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the branch predictor testbench with verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module bpu_tb \
    -o bpu_sim

output=$(./obj_dir/bpu_sim || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

/* verification/bpu_model.svh */
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

localparam int M_BTB_SIZE = 2 ** BTB_IDX_WID;
localparam int M_PHT_SIZE = M_BTB_SIZE * (2 ** HIST_LEN);

logic [HIST_LEN-1:0]     model_ghr;
ctr_t                    model_pht [M_PHT_SIZE];
logic                    model_valid [M_BTB_SIZE];
logic [31:INST_ALIGN_WID] model_tag [M_BTB_SIZE];
u32_t                    model_target [M_BTB_SIZE];

function automatic logic [BTB_IDX_WID-1:0] btb_index(u32_t addr);
    return addr[INST_ALIGN_WID +: BTB_IDX_WID];
endfunction

// pc index bits above the current history.
function automatic int pht_index(u32_t addr);
    return int'({btb_index(addr), model_ghr});
endfunction

function automatic ctr_t counter_step(ctr_t c, logic taken);
    ctr_t n;
    case (c)
        CTR_STRONG_NT: n = taken ? CTR_WEAK_NT : CTR_STRONG_NT;
        CTR_WEAK_NT:   n = taken ? CTR_WEAK_T : CTR_STRONG_NT;
        CTR_WEAK_T:    n = taken ? CTR_STRONG_T : CTR_WEAK_NT;
        default:       n = taken ? CTR_STRONG_T : CTR_WEAK_T;
    endcase
    return n;
endfunction

// power-up contents of all tables.
task automatic model_init();
    for (int i = 0; i < M_PHT_SIZE; i++) begin
        model_pht[i] = CTR_WEAK_NT;
    end
    for (int i = 0; i < M_BTB_SIZE; i++) begin
        model_valid[i] = 1'b0;
        model_tag[i] = '0;
        model_target[i] = '0;
    end
    model_ghr = '0;
endtask

// only history and valid bits see reset.
task automatic model_reset();
    model_ghr = '0;
    for (int i = 0; i < M_BTB_SIZE; i++) begin
        model_valid[i] = 1'b0;
    end
endtask

function automatic btb_predict_t expected_predict(u32_t addr);
    btb_predict_t           p;
    logic [BTB_IDX_WID-1:0] idx;
    logic                   hit;
    idx = btb_index(addr);
    hit = model_valid[idx] && (model_tag[idx] == addr[31:INST_ALIGN_WID]);
    p.valid = hit && (model_pht[pht_index(addr)] >= CTR_WEAK_T);
    p.npc = model_target[idx];
    return p;
endfunction

task automatic model_invalidate(btb_invalid_t inv);
    model_valid[btb_index(inv.pc)] = 1'b0;
endtask

// called after model_invalidate so a taken resolve wins.
task automatic model_resolve(br_resolved_t r);
    int                     p;
    logic [BTB_IDX_WID-1:0] idx;
    p = pht_index(r.pc);
    idx = btb_index(r.pc);
    model_pht[p] = counter_step(model_pht[p], r.taken);
    if (r.taken) begin
        model_valid[idx] = 1'b1;
        model_tag[idx] = r.pc[31:INST_ALIGN_WID];
        model_target[idx] = r.target;
    end
    model_ghr = {model_ghr[HIST_LEN-2:0], r.taken};
endtask

`endif

/* verification/bpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;

    import bpu_pkg::*;

    localparam int BTB_IDX_WID = 4;
    localparam int HIST_LEN = 2;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 2;
    // directed tests need about 53 cycles.
    localparam int DIRECTED_CYCLES = 60;
    localparam int RANDOM_CYCLES = 300;

    localparam br_resolved_t NO_RESOLVE = '0;
    localparam btb_invalid_t NO_INVALID = '0;

    // b and c share a history warmed up by w.
    localparam u32_t PC_B = 32'h0000_1044;
    localparam u32_t PC_C = 32'h0000_1048;
    localparam u32_t PC_W = 32'h0000_3000;
    localparam u32_t PC_POOL [6] = '{32'h0000_1044, 32'h0000_2044, 32'h0000_1048,
                                     32'h0000_3000, 32'h0000_104c, 32'h0000_50fc};

    logic         clk;
    logic         reset;
    logic         stall;
    u32_t         pc;
    br_resolved_t ex_resolved;
    btb_invalid_t btb_invalid;
    btb_predict_t predict;

    `include "bpu_model.svh"

    btb_predict_t exp_q;
    logic         armed = 1'b0;
    string        test_name = "reset";
    int           errors = 0;
    int           checks = 0;
    int           test_errors = 0;
    int           tests_run = 0;
    logic [31:0]  lcg_state;

    // raised after each negedge compare.
    event         checked;

    branch_predictor_top #(
        .BTB_IDX_WID (BTB_IDX_WID),
        .HIST_LEN    (HIST_LEN)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .pc          (pc),
        .predict     (predict),
        .btb_invalid (btb_invalid),
        .ex_resolved (ex_resolved)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int pick(int n);
        logic [31:0] w;
        w = lcg_next();
        return int'(w[30:16]) % n;
    endfunction

    function automatic logic [63:0] pred_value(logic valid, u32_t npc);
        return {31'd0, valid, npc};
    endfunction

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("ok   %s", test_name);
        end else begin
            $display("bad  %s with %0d mismatches", test_name, test_errors);
        end
    endtask

    task automatic drive_cycle(u32_t fpc, logic stl, br_resolved_t r, btb_invalid_t inv);
        @(posedge clk);
        pc <= fpc;
        stall <= stl;
        ex_resolved <= r;
        btb_invalid <= inv;
    endtask

    function automatic br_resolved_t branch(u32_t addr, logic taken, u32_t target);
        br_resolved_t r;
        r.valid = 1'b1;
        r.pc = addr;
        r.taken = taken;
        r.target = target;
        return r;
    endfunction

    task automatic resolve(u32_t addr, logic taken, u32_t target);
        drive_cycle(addr, 1'b0, branch(addr, taken, target), NO_INVALID);
    endtask

    task automatic invalidate(u32_t addr);
        btb_invalid_t inv;
        inv.valid = 1'b1;
        inv.pc = addr;
        drive_cycle(addr, 1'b0, NO_RESOLVE, inv);
    endtask

    // two taken branches leave the history at all ones.
    task automatic warm_history();
        resolve(PC_W, 1'b1, 32'h0000_3100);
        resolve(PC_W, 1'b1, 32'h0000_3100);
    endtask

    // returns after the compare for this lookup.
    task automatic lookup(u32_t addr);
        drive_cycle(addr, 1'b0, NO_RESOLVE, NO_INVALID);
        drive_cycle(addr, 1'b0, NO_RESOLVE, NO_INVALID);
        @(checked);
    endtask

    // model tracks the dut edge by edge with lookup before update.
    always @(posedge clk) begin
        if (reset) begin
            model_reset();
            armed = 1'b0;
        end else begin
            if (!stall) begin
                exp_q = expected_predict(pc);
                armed = 1'b1;
            end
            if (btb_invalid.valid) begin
                model_invalidate(btb_invalid);
            end
            if (ex_resolved.valid) begin
                model_resolve(ex_resolved);
            end
        end
    end

    always @(negedge clk) begin
        if (armed) begin
            check_value(test_name, {31'd0, exp_q}, {31'd0, predict});
        end
        -> checked;
    end

    initial begin
        #(2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD);
        $display("timeout: stimulus still running after %0d cycles",
                 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES));
        $display("Test failures found");
        $finish;
    end

    initial begin
        br_resolved_t res;
        btb_invalid_t inv;
        logic [31:0]  word;
        lcg_state = 32'd50028;
        model_init();
        reset = 1'b1;
        stall = 1'b0;
        pc = '0;
        ex_resolved = NO_RESOLVE;
        btb_invalid = NO_INVALID;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        start_test("reset_lookup");
        for (int i = 0; i < 4; i++) begin
            lookup(PC_POOL[i]);
            check_value(test_name, 64'd0, {63'd0, predict.valid});
        end
        finish_test();

        start_test("training");
        warm_history();
        resolve(PC_B, 1'b1, 32'h0000_2000);
        resolve(PC_B, 1'b1, 32'h0000_2000);
        lookup(PC_B);
        check_value(test_name, pred_value(1'b1, 32'h0000_2000), {31'd0, predict});
        // one resolve reaches weakly taken.
        resolve(PC_C, 1'b1, 32'h0000_2200);
        lookup(PC_C);
        check_value(test_name, pred_value(1'b1, 32'h0000_2200), {31'd0, predict});
        finish_test();

        start_test("saturation");
        for (int i = 0; i < 4; i++) begin
            resolve(PC_B, 1'b0, 32'h0000_2000);
            warm_history();
        end
        lookup(PC_B);
        check_value(test_name, pred_value(1'b0, 32'h0000_2000), {31'd0, predict});
        repeat (4) resolve(PC_B, 1'b1, 32'h0000_2000);
        lookup(PC_B);
        check_value(test_name, pred_value(1'b1, 32'h0000_2000), {31'd0, predict});
        finish_test();

        start_test("invalidate");
        invalidate(PC_B);
        lookup(PC_B);
        check_value(test_name, pred_value(1'b0, 32'h0000_2000), {31'd0, predict});
        inv.valid = 1'b1;
        inv.pc = PC_B;
        drive_cycle(PC_B, 1'b0, branch(PC_B, 1'b1, 32'h0000_2400), inv);
        lookup(PC_B);
        check_value(test_name, pred_value(1'b1, 32'h0000_2400), {31'd0, predict});
        finish_test();

        start_test("stall_hold");
        lookup(PC_B);
        for (int i = 0; i < 4; i++) begin
            res = (i == 0) ? branch(PC_B, 1'b1, 32'h0000_2800) : NO_RESOLVE;
            drive_cycle(PC_C, 1'b1, res, NO_INVALID);
            @(checked);
            check_value(test_name, pred_value(1'b1, 32'h0000_2400), {31'd0, predict});
        end
        lookup(PC_B);
        check_value(test_name, pred_value(1'b1, 32'h0000_2800), {31'd0, predict});
        finish_test();

        start_test("random_mix");
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            res = NO_RESOLVE;
            inv = NO_INVALID;
            if (pick(3) == 0) begin
                word = lcg_next();
                res = branch(PC_POOL[pick(6)], pick(2) == 1, {word[31:2], 2'b00});
            end
            if (pick(6) == 0) begin
                inv.valid = 1'b1;
                inv.pc = PC_POOL[pick(6)];
            end
            drive_cycle(PC_POOL[pick(6)], pick(5) == 0, res, inv);
        end
        drive_cycle(PC_B, 1'b0, NO_RESOLVE, NO_INVALID);
        drive_cycle(PC_B, 1'b0, NO_RESOLVE, NO_INVALID);
        @(checked);
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/branch_predictor_top.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_top #(
    // 16 btb entries.
    parameter int BTB_IDX_WID = 4,
    parameter int HIST_LEN = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,

    input  bpu_pkg::u32_t          pc,
    output bpu_pkg::btb_predict_t  predict,

    input  bpu_pkg::btb_invalid_t  btb_invalid,
    input  bpu_pkg::br_resolved_t  ex_resolved
);

    bpu #(
        .BTB_IDX_WID (BTB_IDX_WID),
        .HIST_LEN    (HIST_LEN)
    ) u_bpu (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .pc          (pc),
        .predict     (predict),
        .btb_invalid (btb_invalid),
        .ex_resolved (ex_resolved)
    );

endmodule

`default_nettype wire

/* rtl/bpu.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu #(
    parameter int BTB_IDX_WID = 4,
    parameter int HIST_LEN = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,

    // fetch stage 1.
    input  bpu_pkg::u32_t          pc,
    output bpu_pkg::btb_predict_t  predict,

    // fetch stage 2.
    input  bpu_pkg::btb_invalid_t  btb_invalid,

    // execute.
    input  bpu_pkg::br_resolved_t  ex_resolved
);

    import bpu_pkg::*;

    localparam int PHT_IDX_WID = BTB_IDX_WID + HIST_LEN;
    localparam int PHT_DEPTH = (2 ** BTB_IDX_WID) * (2 ** HIST_LEN);

    logic [HIST_LEN-1:0]    ghr;
    logic [PHT_IDX_WID-1:0] pht_wr_idx;
    logic [PHT_IDX_WID-1:0] pht_lookup_idx;

    ctr_t ctr_old;
    ctr_t ctr_next;
    ctr_t ctr_lookup;

    u32_t target_pc;
    logic target_valid;

    // global history, updated at resolve only.
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (ex_resolved.valid) begin
            ghr <= (ghr << 1) | HIST_LEN'(ex_resolved.taken);
        end
    end

    assign pht_wr_idx     = {ex_resolved.pc[INST_ALIGN_WID +: BTB_IDX_WID], ghr};
    assign pht_lookup_idx = {pc[INST_ALIGN_WID +: BTB_IDX_WID], ghr};

    // saturating counter step.
    always_comb begin
        ctr_next = ctr_old;
        if (ex_resolved.taken) begin
            if (ctr_old != CTR_STRONG_T) begin
                ctr_next = ctr_t'(ctr_old + 2'd1);
            end
        end else begin
            if (ctr_old != CTR_STRONG_NT) begin
                ctr_next = ctr_t'(ctr_old - 2'd1);
            end
        end
    end

    dual_port_ram #(
        .data_t (ctr_t),
        .DEPTH  (PHT_DEPTH),
        .INIT   (CTR_WEAK_NT)
    ) u_pht (
        .clk   (clk),
        .wen   (ex_resolved.valid),
        .waddr (pht_wr_idx),
        .wdata (ctr_next),
        .wq    (ctr_old),
        .ren   (~stall),
        .raddr (pht_lookup_idx),
        .rq    (ctr_lookup)
    );

    btb #(
        .BTB_IDX_WID (BTB_IDX_WID)
    ) u_btb (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .pc           (pc),
        .btb_invalid  (btb_invalid),
        .ex_resolved  (ex_resolved),
        .target_pc    (target_pc),
        .target_valid (target_valid)
    );

    assign predict.valid = target_valid & (ctr_lookup inside {CTR_WEAK_T, CTR_STRONG_T});
    assign predict.npc   = target_pc;

    resolve_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(ex_resolved.valid)
    ) else $error("ex_resolved.valid is unknown");

endmodule

`default_nettype wire

/* rtl/btb.sv */
`timescale 1ns/1ps
`default_nettype none

module btb #(
    parameter int BTB_IDX_WID = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,

    // lookup from fetch stage 1.
    input  bpu_pkg::u32_t          pc,

    // invalidate from fetch stage 2.
    input  bpu_pkg::btb_invalid_t  btb_invalid,

    // resolve from execute.
    input  bpu_pkg::br_resolved_t  ex_resolved,

    output bpu_pkg::u32_t          target_pc,
    output logic                   target_valid
);

    import bpu_pkg::*;

    localparam int BTB_SIZE = 2 ** BTB_IDX_WID;

    logic [BTB_IDX_WID-1:0] rd_idx;
    logic [BTB_IDX_WID-1:0] wr_idx;
    logic [BTB_IDX_WID-1:0] inv_idx;

    logic       btb_wen;
    btb_entry_t wr_entry;
    btb_entry_t rd_entry;

    logic [BTB_SIZE-1:0]     valid_q;
    logic                    lookup_valid_q;
    logic [31:INST_ALIGN_WID] lookup_word_q;

    assign rd_idx  = pc[INST_ALIGN_WID +: BTB_IDX_WID];
    assign wr_idx  = ex_resolved.pc[INST_ALIGN_WID +: BTB_IDX_WID];
    assign inv_idx = btb_invalid.pc[INST_ALIGN_WID +: BTB_IDX_WID];

    // only taken branches allocate.
    assign btb_wen         = ex_resolved.valid & ex_resolved.taken;
    assign wr_entry.tag    = ex_resolved.pc[31:INST_ALIGN_WID];
    assign wr_entry.target = ex_resolved.target;

    dual_port_ram #(
        .data_t (btb_entry_t),
        .DEPTH  (BTB_SIZE),
        .INIT   (btb_entry_t'(0))
    ) u_btb_ram (
        .clk   (clk),
        .wen   (btb_wen),
        .waddr (wr_idx),
        .wdata (wr_entry),
        .wq    (),
        .ren   (~stall),
        .raddr (rd_idx),
        .rq    (rd_entry)
    );

    // a set after a clear on the same index leaves it valid.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (btb_invalid.valid) begin
                valid_q[inv_idx] <= 1'b0;
            end
            if (btb_wen) begin
                valid_q[wr_idx] <= 1'b1;
            end
        end
    end

    // lookup stage, frozen by stall.
    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_valid_q <= 1'b0;
        end else if (!stall) begin
            lookup_valid_q <= valid_q[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            lookup_word_q <= pc[31:INST_ALIGN_WID];
        end
    end

    assign target_valid = lookup_valid_q & (rd_entry.tag == lookup_word_q);
    assign target_pc    = rd_entry.target;

    no_hit_after_reset: assert property (
        @(posedge clk) reset |=> !target_valid
    ) else $error("btb reports a hit right after reset");

endmodule

`default_nettype wire

/* rtl/dual_port_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter type data_t = logic [31:0],
    parameter int DEPTH = 16,
    parameter data_t INIT = data_t'(0),
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk,

    // write port with asynchronous read of the same address.
    input  logic          wen,
    input  logic [AW-1:0] waddr,
    input  data_t         wdata,
    output data_t         wq,

    // registered lookup port.
    input  logic          ren,
    input  logic [AW-1:0] raddr,
    output data_t         rq
);

    data_t mem [DEPTH] = '{default: INIT};

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    assign wq = mem[waddr];

    // holds the last lookup while ren is low.
    always_ff @(posedge clk) begin
        if (ren) begin
            rq <= mem[raddr];
        end
    end

    waddr_in_range: assert property (
        @(posedge clk) wen |-> (int'(waddr) < DEPTH)
    ) else $error("dual_port_ram write address %0d out of range", waddr);

endmodule

`default_nettype wire

/* rtl/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    typedef logic [31:0] u32_t;

    // low pc bits dropped before indexing.
    localparam int INST_ALIGN_WID = 2;

    // 2-bit saturating branch counter.
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } ctr_t;

    // resolved branch from execute.
    typedef struct packed {
        logic valid;
        u32_t pc;
        logic taken;
        u32_t target;
    } br_resolved_t;

    // bad prediction report from fetch stage 2.
    typedef struct packed {
        logic valid;
        u32_t pc;
    } btb_invalid_t;

    // prediction returned to fetch stage 1.
    typedef struct packed {
        logic valid;
        u32_t npc;
    } btb_predict_t;

    // full word address as tag, independent of the index width.
    typedef struct packed {
        logic [31:INST_ALIGN_WID] tag;
        u32_t                     target;
    } btb_entry_t;

endpackage

`default_nettype wire
